//--- dv/decode_checker.sv
`timescale 1ns/1ns
`default_nettype none

module decode_checker
	import mips_decode_pkg::*;
#(
	parameter int          NUM_TESTS = 1,
	parameter logic [31:0] PC_BASE   = 32'h0
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            out_valid,
	input  dec_pkt_t        out_pkt,
	input  logic            out_credit,
	input  logic [31:0]     exp_instr [NUM_TESTS],
	input  dec_ctrl_t       exp_ctrl  [NUM_TESTS],
	input  alu_op_e         exp_alu   [NUM_TESTS],
	input  logic [8*12-1:0] exp_name  [NUM_TESTS],
	output int              tests_done,
	output int              tests_failed,
	output int              other_errors
);

	int outstanding;   // bundles seen minus credits returned
	int field_errs;

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
			field_errs++;
		end
	endtask

	task automatic check_bundle(input int idx);
		dec_ctrl_t e;
		dec_ctrl_t a;
		e = exp_ctrl[idx];
		a = out_pkt.ctrl;
		field_errs = 0;
		check_field("out_pkt.pc", PC_BASE + 32'(idx) * 32'd4, out_pkt.pc);
		check_field("out_pkt.instr", exp_instr[idx], out_pkt.instr);
		check_field("out_pkt.alu_op", 32'(exp_alu[idx]), 32'(out_pkt.alu_op));
		check_field("ctrl.sign_ext", 32'(e.sign_ext), 32'(a.sign_ext));
		check_field("ctrl.is_div", 32'(e.is_div), 32'(a.is_div));
		check_field("ctrl.is_mult", 32'(e.is_mult), 32'(a.is_mult));
		check_field("ctrl.mfhi_lo", 32'(e.mfhi_lo), 32'(a.mfhi_lo));
		check_field("ctrl.reg_dst", 32'(e.reg_dst), 32'(a.reg_dst));
		check_field("ctrl.alu_imm_sel", 32'(e.alu_imm_sel), 32'(a.alu_imm_sel));
		check_field("ctrl.hilo_wen", 32'(e.hilo_wen), 32'(a.hilo_wen));
		check_field("ctrl.mem_read_en", 32'(e.mem_read_en), 32'(a.mem_read_en));
		check_field("ctrl.mem_write_en", 32'(e.mem_write_en), 32'(a.mem_write_en));
		check_field("ctrl.reg_write_en", 32'(e.reg_write_en), 32'(a.reg_write_en));
		check_field("ctrl.mem_to_reg", 32'(e.mem_to_reg), 32'(a.mem_to_reg));
		check_field("ctrl.hilo_to_reg", 32'(e.hilo_to_reg), 32'(a.hilo_to_reg));
		check_field("ctrl.ri", 32'(e.ri), 32'(a.ri));
		check_field("ctrl.brk", 32'(e.brk), 32'(a.brk));
		check_field("ctrl.syscall", 32'(e.syscall), 32'(a.syscall));
		check_field("ctrl.eret", 32'(e.eret), 32'(a.eret));
		check_field("ctrl.cp0_wen", 32'(e.cp0_wen), 32'(a.cp0_wen));
		check_field("ctrl.cp0_to_reg", 32'(e.cp0_to_reg), 32'(a.cp0_to_reg));
		check_field("ctrl.ls_type", 32'(e.ls_type), 32'(a.ls_type));
		check_field("ctrl.tlb_type", 32'(e.tlb_type), 32'(a.tlb_type));
		if (field_errs == 0) begin
			$display("[%0t] PASS  %0d %s", $time, idx, exp_name[idx]);
		end else begin
			$display("[%0t] FAIL  %0d %s, %0d fields wrong", $time, idx, exp_name[idx],
				field_errs);
			tests_failed++;
		end
		tests_done++;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tests_done   = 0;
			tests_failed = 0;
			other_errors = 0;
			outstanding  = 0;
		end else begin
			if (out_valid)
				outstanding++;
			if (out_credit)
				outstanding--;
			if (outstanding > DEC_CREDITS) begin
				$display("at %0t ns %0d bundles are outstanding but only %0d credits exist",
					$time, outstanding, DEC_CREDITS);
				other_errors++;
			end
			if (out_valid) begin
				if (tests_done >= NUM_TESTS) begin
					$display("at %0t ns an extra bundle arrived after the last test, pc %h",
						$time, out_pkt.pc);
					other_errors++;
				end else begin
					check_bundle(tests_done);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/decode_tb.sv
`timescale 1ns/1ns
`default_nettype none

module decode_tb
	import mips_decode_pkg::*;
;

	localparam int          NUM_TESTS    = 40;
	localparam int          RESET_CYCLES = 5;
	localparam int          WDOG_CYCLES  = NUM_TESTS * 20 + RESET_CYCLES;
	localparam logic [31:0] PC_BASE      = 32'h0040_0000;

	// expected behavior class of each table entry
	typedef enum {
		K_R_ALU, K_MULT, K_DIV, K_HILO_W, K_NONE, K_IMM_SE, K_IMM_ZE, K_LOAD, K_STORE,
		K_LINK, K_MFHI, K_MFLO, K_MFC0, K_MTC0, K_SYSCALL, K_BREAK, K_ERET, K_TLB, K_RI
	} kind_e;

	logic       clk        = 1'b0;
	logic       arst_n     = 1'b0;
	logic       in_valid   = 1'b0;
	fetch_pkt_t in_pkt     = '0;
	logic       out_credit = 1'b0;
	logic       in_credit;
	logic       out_valid;
	dec_pkt_t   out_pkt;

	logic [31:0]     exp_instr [NUM_TESTS];
	dec_ctrl_t       exp_ctrl  [NUM_TESTS];
	alu_op_e         exp_alu   [NUM_TESTS];
	logic [8*12-1:0] exp_name  [NUM_TESTS];
	int              n_tests;

	int          up_sent;
	int          up_returned;
	int          tb_errors;
	int          tests_done;
	int          tests_failed;
	int          other_errors;
	int unsigned due_q [$];   // cycles at which execute frees a slot
	int unsigned down_cycle;

	always #20 clk = ~clk;

	decode_top decode_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_pkt     (in_pkt),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_credit (out_credit)
	);

	decode_checker #(
		.NUM_TESTS (NUM_TESTS),
		.PC_BASE   (PC_BASE)
	) checker_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.out_valid    (out_valid),
		.out_pkt      (out_pkt),
		.out_credit   (out_credit),
		.exp_instr    (exp_instr),
		.exp_ctrl     (exp_ctrl),
		.exp_alu      (exp_alu),
		.exp_name     (exp_name),
		.tests_done   (tests_done),
		.tests_failed (tests_failed),
		.other_errors (other_errors)
	);

	// onehot carries the ls_type of memory ops or the tlb_type of tlb ops
	function automatic dec_ctrl_t expected_ctrl(input kind_e k, input logic [7:0] onehot);
		dec_ctrl_t c;
		c          = '0;
		c.reg_dst  = DST_RD;
		c.sign_ext = (k != K_IMM_ZE);   // only andi, ori, xori, lui zero extend
		case (k)
			K_R_ALU: c.reg_write_en = 1'b1;
			K_MULT: begin
				c.hilo_wen = 1'b1;
				c.is_mult  = 1'b1;
			end
			K_DIV: begin
				c.hilo_wen = 1'b1;
				c.is_div   = 1'b1;
			end
			K_HILO_W: c.hilo_wen = 1'b1;
			K_IMM_SE, K_IMM_ZE: begin
				c.reg_write_en = 1'b1;
				c.reg_dst      = DST_RT;
				c.alu_imm_sel  = 1'b1;
			end
			K_LOAD: begin
				c.reg_write_en = 1'b1;
				c.reg_dst      = DST_RT;
				c.alu_imm_sel  = 1'b1;
				c.mem_read_en  = 1'b1;
				c.mem_to_reg   = 1'b1;
				c.ls_type      = onehot;
			end
			K_STORE: begin
				c.alu_imm_sel  = 1'b1;
				c.mem_write_en = 1'b1;
				c.ls_type      = onehot;
			end
			K_LINK: begin
				c.reg_write_en = 1'b1;
				c.reg_dst      = DST_RA;
			end
			K_MFHI, K_MFLO: begin
				c.reg_write_en = 1'b1;
				c.hilo_to_reg  = 1'b1;
				c.mfhi_lo      = (k == K_MFHI) ? 2'b10 : 2'b01;
			end
			K_MFC0: begin
				c.reg_write_en = 1'b1;
				c.reg_dst      = DST_RT;
				c.cp0_to_reg   = 1'b1;
			end
			K_MTC0:    c.cp0_wen  = 1'b1;
			K_SYSCALL: c.syscall  = 1'b1;
			K_BREAK:   c.brk      = 1'b1;
			K_ERET:    c.eret     = 1'b1;
			K_TLB:     c.tlb_type = onehot[3:0];
			K_RI:      c.ri       = 1'b1;
			default: ;   // branches and jr write nothing
		endcase
		return c;
	endfunction

	task automatic add_test(input logic [31:0] instr, input kind_e k, input logic [7:0] onehot,
		input alu_op_e alu, input logic [8*12-1:0] name);
		exp_instr[n_tests] = instr;
		exp_ctrl[n_tests]  = expected_ctrl(k, onehot);
		exp_alu[n_tests]   = alu;
		exp_name[n_tests]  = name;
		n_tests++;
	endtask

	task automatic fill_table();
		n_tests = 0;
		add_test(32'h01095020, K_R_ALU,   8'h00, ALU_ADD,  "add");
		add_test(32'h01095023, K_R_ALU,   8'h00, ALU_SUBU, "subu");
		add_test(32'h01095027, K_R_ALU,   8'h00, ALU_NOR,  "nor");
		add_test(32'h01095004, K_R_ALU,   8'h00, ALU_SLL,  "sllv");
		add_test(32'h0109502a, K_R_ALU,   8'h00, ALU_SLT,  "slt");
		add_test(32'h01090018, K_MULT,    8'h00, ALU_NONE, "mult");
		add_test(32'h0109001a, K_DIV,     8'h00, ALU_NONE, "div");
		add_test(32'h01000011, K_HILO_W,  8'h00, ALU_NONE, "mthi");
		add_test(32'h03e00008, K_NONE,    8'h00, ALU_NONE, "jr");
		add_test(32'h2109fffc, K_IMM_SE,  8'h00, ALU_ADD,  "addi");
		add_test(32'h29090010, K_IMM_SE,  8'h00, ALU_SLT,  "slti");
		add_test(32'h310900ff, K_IMM_ZE,  8'h00, ALU_AND,  "andi");
		add_test(32'h35091234, K_IMM_ZE,  8'h00, ALU_OR,   "ori");
		add_test(32'h39090f0f, K_IMM_ZE,  8'h00, ALU_XOR,  "xori");
		add_test(32'h3c09abcd, K_IMM_ZE,  8'h00, ALU_LUI,  "lui");
		add_test(32'h8d090008, K_LOAD,    8'h80, ALU_ADDU, "lw");
		add_test(32'h91090003, K_LOAD,    8'h08, ALU_ADDU, "lbu");
		add_test(32'ha5090002, K_STORE,   8'h02, ALU_ADDU, "sh");
		add_test(32'ha1090001, K_STORE,   8'h01, ALU_ADDU, "sb");
		add_test(32'h0c100010, K_LINK,    8'h00, ALU_PASS, "jal");
		add_test(32'h0100f809, K_LINK,    8'h00, ALU_PASS, "jalr");
		add_test(32'h05110004, K_LINK,    8'h00, ALU_PASS, "bgezal");
		add_test(32'h11090004, K_NONE,    8'h00, ALU_NONE, "beq");
		add_test(32'h08100000, K_NONE,    8'h00, ALU_NONE, "j");
		add_test(32'h05000004, K_NONE,    8'h00, ALU_NONE, "bltz");
		add_test(32'h00005010, K_MFHI,    8'h00, ALU_PASS, "mfhi");
		add_test(32'h00005012, K_MFLO,    8'h00, ALU_PASS, "mflo");
		add_test(32'h40096000, K_MFC0,    8'h00, ALU_PASS, "mfc0");
		add_test(32'h40896000, K_MTC0,    8'h00, ALU_NONE, "mtc0");
		add_test(32'h0000000c, K_SYSCALL, 8'h00, ALU_NONE, "syscall");
		add_test(32'h0000000d, K_BREAK,   8'h00, ALU_NONE, "break");
		add_test(32'h42000018, K_ERET,    8'h00, ALU_NONE, "eret");
		add_test(32'h42000001, K_TLB,     8'h02, ALU_NONE, "tlbr");
		add_test(32'h42000002, K_TLB,     8'h04, ALU_NONE, "tlbwi");
		add_test(32'h42000006, K_TLB,     8'h08, ALU_NONE, "tlbwr");
		add_test(32'h42000008, K_TLB,     8'h01, ALU_NONE, "tlbp");
		add_test(32'hfc000000, K_RI,      8'h00, ALU_NONE, "bad_opcode");
		add_test(32'h0000003f, K_RI,      8'h00, ALU_NONE, "bad_funct");
		add_test(32'h05050000, K_RI,      8'h00, ALU_NONE, "bad_regimm");
		add_test(32'h4200003f, K_RI,      8'h00, ALU_NONE, "bad_cop0");
	endtask

	// queue credits become usable after the edge that frees the slot
	always @(posedge clk) begin
		if (arst_n && in_credit) begin
			up_returned++;
			if (up_returned > up_sent) begin
				$display("at %0t ns the queue returned more credits than it was sent", $time);
				tb_errors++;
			end
		end
	end

	// execute model frees each slot 0 to 5 cycles after the bundle lands
	always @(negedge clk) begin
		if (arst_n) begin
			down_cycle++;
			out_credit = 1'b0;
			if (out_valid)
				due_q.push_back(down_cycle + $urandom_range(0, 5));
			if (due_q.size() > 0 && due_q[0] <= down_cycle) begin
				out_credit = 1'b1;
				void'(due_q.pop_front());
			end
		end
	end

	initial begin
		repeat (WDOG_CYCLES) @(posedge clk);
		$display("timeout: output stalled after %0d of %0d bundles", tests_done, NUM_TESTS);
		$display("Test failed");
		$finish;
	end

	initial begin
		int gap;
		void'($urandom(32'h7dce));
		up_sent     = 0;
		up_returned = 0;
		tb_errors   = 0;
		down_cycle  = 0;
		fill_table();
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		for (int i = 0; i < NUM_TESTS; i++) begin
			gap = $urandom_range(0, 2);
			repeat (gap) @(negedge clk);
			while (up_sent - up_returned >= QUEUE_DEPTH)   // out of credits
				@(negedge clk);
			in_valid     = 1'b1;
			in_pkt.instr = exp_instr[i];
			in_pkt.pc    = PC_BASE + 32'(i) * 32'd4;
			up_sent++;
			@(negedge clk);
			in_valid = 1'b0;
		end

		while (tests_done < NUM_TESTS)
			@(negedge clk);
		repeat (10) @(negedge clk);   // room for stray bundles
		if (up_returned != NUM_TESTS) begin
			$display("the queue returned %0d credits for %0d sends", up_returned, NUM_TESTS);
			tb_errors++;
		end

		$display("totals: %0d tests, %0d failed, %0d other errors", tests_done, tests_failed,
			other_errors + tb_errors);
		if (tests_failed == 0 && other_errors == 0 && tb_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
src/mips_decode_pkg.sv
src/instr_queue.sv
src/main_decoder.sv
src/alu_decoder.sv
src/decode_stage.sv
src/decode_top.sv
dv/decode_checker.sv
dv/decode_tb.sv

//--- run.sh
#!/bin/sh
# builds the decode testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f filelist.f --top-module decode_tb \
	-Mdir obj_dir -o decode_sim &&
./obj_dir/decode_sim | tee /dev/stderr | grep -q "Test passed" &&
echo "run.sh: simulation PASS" ||
{ echo "run.sh: simulation FAIL"; exit 1; }

//--- src/alu_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module alu_decoder
	import mips_decode_pkg::*;
(
	input  logic [31:0] instr,
	output alu_op_e     alu_op
);

	opcode_e    opcode;
	cop0_rs_e   rs;
	logic [4:0] rt;
	funct_e     funct;

	assign opcode = opcode_e'(instr[31:26]);
	assign rs     = cop0_rs_e'(instr[25:21]);
	assign rt     = instr[20:16];
	assign funct  = funct_e'(instr[5:0]);

	always_comb begin
		alu_op = ALU_NONE;
		case (opcode)
			OP_R_TYPE: begin
				case (funct)
					FN_ADD:           alu_op = ALU_ADD;
					FN_ADDU:          alu_op = ALU_ADDU;
					FN_SUB:           alu_op = ALU_SUB;
					FN_SUBU:          alu_op = ALU_SUBU;
					FN_AND:           alu_op = ALU_AND;
					FN_OR:            alu_op = ALU_OR;
					FN_XOR:           alu_op = ALU_XOR;
					FN_NOR:           alu_op = ALU_NOR;
					FN_SLT:           alu_op = ALU_SLT;
					FN_SLTU:          alu_op = ALU_SLTU;
					FN_SLL, FN_SLLV:  alu_op = ALU_SLL;   // shamt or rs picked in execute
					FN_SRL, FN_SRLV:  alu_op = ALU_SRL;
					FN_SRA, FN_SRAV:  alu_op = ALU_SRA;
					FN_MFHI, FN_MFLO: alu_op = ALU_PASS;
					FN_JALR:          alu_op = ALU_PASS;  // link address
					default:          alu_op = ALU_NONE;
				endcase
			end

			OP_ADDI:  alu_op = ALU_ADD;
			OP_ADDIU: alu_op = ALU_ADDU;
			OP_SLTI:  alu_op = ALU_SLT;
			OP_SLTIU: alu_op = ALU_SLTU;
			OP_ANDI:  alu_op = ALU_AND;
			OP_ORI:   alu_op = ALU_OR;
			OP_XORI:  alu_op = ALU_XOR;
			OP_LUI:   alu_op = ALU_LUI;

			// effective address
			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_SW, OP_SH, OP_SB:
				alu_op = ALU_ADDU;

			OP_MUL: alu_op = ALU_MUL;
			OP_JAL: alu_op = ALU_PASS;

			OP_REGIMM: begin
				if (rt[4:1] == 4'b1000)
					alu_op = ALU_PASS;   // bltzal, bgezal
			end

			OP_COP0: begin
				if (rs == C0_MFC0)
					alu_op = ALU_PASS;
			end

			default: alu_op = ALU_NONE;
		endcase
	end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage
	import mips_decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       head_valid,
	input  fetch_pkt_t head_pkt,
	output logic       pop,
	output logic       out_valid,
	output dec_pkt_t   out_pkt,
	input  logic       out_credit
);

	logic [CRED_W-1:0] credits;   // free slots in execute
	logic              send;
	dec_ctrl_t         ctrl;
	alu_op_e           alu_op;

	assign send = head_valid && (credits != '0);
	assign pop  = send;

	main_decoder main_dec_inst (
		.instr (head_pkt.instr),
		.ctrl  (ctrl)
	);

	alu_decoder alu_dec_inst (
		.instr  (head_pkt.instr),
		.alu_op (alu_op)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits   <= CRED_W'(DEC_CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= send;
			case ({send, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;   // idle, or send and return in one cycle
			endcase
		end
	end

	// bundle register loads on each send
	always_ff @(posedge clk) begin
		if (send) begin
			out_pkt.ctrl   <= ctrl;
			out_pkt.alu_op <= alu_op;
			out_pkt.instr  <= head_pkt.instr;
			out_pkt.pc     <= head_pkt.pc;
		end
	end

	// execute never returns more credits than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= CRED_W'(DEC_CREDITS))
		else $error("decode_stage: credit count above DEC_CREDITS");

endmodule

`default_nettype wire

//--- src/decode_top.sv
`timescale 1ns/1ns
`default_nettype none

module decode_top
	import mips_decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  fetch_pkt_t in_pkt,
	output logic       in_credit,
	output logic       out_valid,
	output dec_pkt_t   out_pkt,
	input  logic       out_credit
);

	logic       head_valid;
	fetch_pkt_t head_pkt;
	logic       pop;

	instr_queue queue_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_pkt     (in_pkt),
		.pop        (pop),
		.head_valid (head_valid),
		.head_pkt   (head_pkt),
		.in_credit  (in_credit)
	);

	decode_stage stage_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.head_valid (head_valid),
		.head_pkt   (head_pkt),
		.pop        (pop),
		.out_valid  (out_valid),
		.out_pkt    (out_pkt),
		.out_credit (out_credit)
	);

endmodule

`default_nettype wire

//--- src/instr_queue.sv
`timescale 1ns/1ns
`default_nettype none

module instr_queue
	import mips_decode_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  fetch_pkt_t in_pkt,
	input  logic       pop,
	output logic       head_valid,
	output fetch_pkt_t head_pkt,
	output logic       in_credit
);

	fetch_pkt_t        mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] count;
	logic              full;

	assign full       = (count == QCNT_W'(QUEUE_DEPTH));
	assign head_valid = (count != '0);
	assign head_pkt   = mem[rd_ptr];
	assign in_credit  = pop;   // each freed slot goes back upstream as a credit

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_pkt;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// upstream must respect its credits
	a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
		!(in_valid && full))
		else $error("instr_queue: write while full");

	// decode stage pops only a valid head
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		!(pop && !head_valid))
		else $error("instr_queue: pop while empty");

endmodule

`default_nettype wire

//--- src/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder
	import mips_decode_pkg::*;
(
	input  logic [31:0] instr,
	output dec_ctrl_t   ctrl
);

	opcode_e     opcode;
	cop0_rs_e    rs;
	logic [4:0]  rt;
	funct_e      funct;
	cop0_funct_e c0_funct;

	assign opcode   = opcode_e'(instr[31:26]);
	assign rs       = cop0_rs_e'(instr[25:21]);
	assign rt       = instr[20:16];
	assign funct    = funct_e'(instr[5:0]);
	assign c0_funct = cop0_funct_e'(instr[5:0]);

	// one-hot access type with lw at the top and sb at the bottom
	function automatic logic [7:0] ls_onehot(input opcode_e op);
		logic [7:0] t;
		t = '0;
		case (op)
			OP_LW:   t[7] = 1'b1;
			OP_LH:   t[6] = 1'b1;
			OP_LHU:  t[5] = 1'b1;
			OP_LB:   t[4] = 1'b1;
			OP_LBU:  t[3] = 1'b1;
			OP_SW:   t[2] = 1'b1;
			OP_SH:   t[1] = 1'b1;
			OP_SB:   t[0] = 1'b1;
			default: t = '0;
		endcase
		return t;
	endfunction

	always_comb begin
		ctrl          = '0;
		ctrl.reg_dst  = DST_RD;
		// logical immediates are zero extended
		ctrl.sign_ext = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
		ctrl.ls_type  = ls_onehot(opcode);

		case (opcode)
			OP_R_TYPE: begin
				case (funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
						ctrl.reg_write_en = 1'b1;
					FN_MFHI: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.hilo_to_reg  = 1'b1;
						ctrl.mfhi_lo      = 2'b10;
					end
					FN_MFLO: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.hilo_to_reg  = 1'b1;
						ctrl.mfhi_lo      = 2'b01;
					end
					FN_MTHI, FN_MTLO:
						ctrl.hilo_wen = 1'b1;
					FN_MULT, FN_MULTU: begin
						ctrl.hilo_wen = 1'b1;
						ctrl.is_mult  = 1'b1;
					end
					FN_DIV, FN_DIVU: begin
						ctrl.hilo_wen = 1'b1;
						ctrl.is_div   = 1'b1;
					end
					FN_JR: ;   // jump only
					FN_JALR: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = DST_RA;   // link always to r31
					end
					FN_SYSCALL: ctrl.syscall = 1'b1;
					FN_BREAK:   ctrl.brk     = 1'b1;
					default:    ctrl.ri      = 1'b1;
				endcase
			end

			OP_REGIMM: begin
				case (rt[4:1])
					4'b1000: begin   // bltzal, bgezal
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = DST_RA;
					end
					4'b0000: ;       // bltz, bgez
					default: ctrl.ri = 1'b1;
				endcase
			end

			OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ;

			OP_JAL: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = DST_RA;
			end

			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = DST_RT;
				ctrl.alu_imm_sel  = 1'b1;
			end

			OP_LW, OP_LB, OP_LBU, OP_LH, OP_LHU: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.reg_dst      = DST_RT;
				ctrl.alu_imm_sel  = 1'b1;
				ctrl.mem_read_en  = 1'b1;
				ctrl.mem_to_reg   = 1'b1;
			end

			OP_SW, OP_SH, OP_SB: begin
				ctrl.alu_imm_sel  = 1'b1;   // address = base + offset
				ctrl.mem_write_en = 1'b1;
			end

			OP_COP0: begin
				case (rs)
					C0_MTC0: ctrl.cp0_wen = 1'b1;
					C0_MFC0: begin
						ctrl.reg_write_en = 1'b1;
						ctrl.reg_dst      = DST_RT;
						ctrl.cp0_to_reg   = 1'b1;
					end
					default: begin
						case (c0_funct)
							C0_TLBWR: ctrl.tlb_type = 4'b1000;
							C0_TLBWI: ctrl.tlb_type = 4'b0100;
							C0_TLBR:  ctrl.tlb_type = 4'b0010;
							C0_TLBP:  ctrl.tlb_type = 4'b0001;
							C0_ERET:  ctrl.eret     = 1'b1;
							default:  ctrl.ri       = 1'b1;
						endcase
					end
				endcase
			end

			OP_MUL: begin   // SPECIAL2 mul writes its result straight to rd
				ctrl.reg_write_en = 1'b1;
				ctrl.is_mult      = 1'b1;
			end

			default: ctrl.ri = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- src/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

	localparam int QUEUE_DEPTH = 4;   // also the upstream credit budget
	localparam int DEC_CREDITS = 2;   // bundle slots granted by execute
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
	localparam int CRED_W      = $clog2(DEC_CREDITS + 1);

	// primary opcode in instr[31:26]
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ    = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI   = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI   = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_COP0   = 6'h10, OP_MUL    = 6'h1c,
		OP_LB     = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU    = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
	} opcode_e;

	// SPECIAL funct in instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV  = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
		FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d,
		FN_MFHI = 6'h10, FN_MTHI  = 6'h11, FN_MFLO    = 6'h12, FN_MTLO  = 6'h13,
		FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV     = 6'h1a, FN_DIVU  = 6'h1b,
		FN_ADD  = 6'h20, FN_ADDU  = 6'h21, FN_SUB     = 6'h22, FN_SUBU  = 6'h23,
		FN_AND  = 6'h24, FN_OR    = 6'h25, FN_XOR     = 6'h26, FN_NOR   = 6'h27,
		FN_SLT  = 6'h2a, FN_SLTU  = 6'h2b
	} funct_e;

	typedef enum logic [5:0] {
		C0_TLBR = 6'h01, C0_TLBWI = 6'h02, C0_TLBWR = 6'h06, C0_TLBP = 6'h08, C0_ERET = 6'h18
	} cop0_funct_e;

	typedef enum logic [4:0] {
		C0_MFC0 = 5'h00, C0_MTC0 = 5'h04
	} cop0_rs_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_MUL, ALU_PASS,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [1:0] {
		DST_RD = 2'b00, DST_RT = 2'b01, DST_RA = 2'b10   // ra is r31
	} reg_dst_e;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
	} fetch_pkt_t;

	typedef struct packed {
		logic       sign_ext;
		logic       is_div;
		logic       is_mult;
		logic [1:0] mfhi_lo;      // {mfhi, mflo}
		reg_dst_e   reg_dst;
		logic       alu_imm_sel;
		logic       hilo_wen;
		logic       mem_read_en;
		logic       mem_write_en;
		logic       reg_write_en;
		logic       mem_to_reg;
		logic       hilo_to_reg;
		logic       ri;
		logic       brk;
		logic       syscall;
		logic       eret;
		logic       cp0_wen;
		logic       cp0_to_reg;
		logic [7:0] ls_type;      // {lw, lh, lhu, lb, lbu, sw, sh, sb}
		logic [3:0] tlb_type;     // {wr, wi, r, p}
	} dec_ctrl_t;

	typedef struct packed {
		dec_ctrl_t   ctrl;
		alu_op_e     alu_op;
		logic [31:0] instr;
		logic [31:0] pc;
	} dec_pkt_t;

endpackage

`default_nettype wire
